//--- dcache_pkg.sv
package dcache_pkg;

    localparam int WORD_BITS   = 32;
    localparam int STROBE_BITS = 4;
    localparam int ALIGN_BITS  = 2;
    localparam int ADDR_BITS   = 32;

    // one strobe bit widens to its byte lane
    function automatic logic [WORD_BITS-1:0] byte_mask(
        input logic [STROBE_BITS-1:0] strobe
    );
        logic [WORD_BITS-1:0] mask;
        for (int b = 0; b < STROBE_BITS; b++) begin
            mask[b*8 +: 8] = {8{strobe[b]}};
        end
        return mask;
    endfunction

endpackage

//--- dcache_if.sv
`timescale 1ns/1ps

// accepted hit, handed from lookup to the data array
interface lookup_if #(
    parameter int SETS       = 16,
    parameter int WAYS       = 4,
    parameter int LINE_WORDS = 8
);
    import dcache_pkg::*;

    logic                          fire;
    logic [$clog2(WAYS)-1:0]       way;
    logic [$clog2(SETS)-1:0]       index;
    logic [$clog2(LINE_WORDS)-1:0] offset;
    logic [STROBE_BITS-1:0]        strobe;
    logic [WORD_BITS-1:0]          wdata;

    modport source (output fire, way, index, offset, strobe, wdata);
    modport sink   (input fire, way, index, offset, strobe, wdata);
endinterface

// miss engine access to the second array port
interface fill_if #(
    parameter int SETS       = 16,
    parameter int WAYS       = 4,
    parameter int LINE_WORDS = 8
);
    import dcache_pkg::*;

    logic                          en;
    logic                          we;
    logic [$clog2(WAYS)-1:0]       way;
    logic [$clog2(SETS)-1:0]       index;
    logic [$clog2(LINE_WORDS)-1:0] offset;
    logic [WORD_BITS-1:0]          wdata;
    logic [WORD_BITS-1:0]          rdata;

    modport engine (output en, we, way, index, offset, wdata, input rdata);
    modport array  (input en, we, way, index, offset, wdata, output rdata);
endinterface

//--- plru_tree.sv
`timescale 1ns/1ps

module plru_tree #(
    parameter int  WAYS     = 4,
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic [WAYS-2:0]     tree_bits,
    input  logic [WAY_BITS-1:0] hit_way,
    output logic [WAY_BITS-1:0] victim_way,
    output logic [WAYS-2:0]     tree_next
);

    // node n has children 2n+1 and 2n+2, a set bit points right
    always_comb begin
        int node;
        node = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            victim_way[WAY_BITS-1-lvl] = tree_bits[node];
            node = 2 * node + 1 + int'(tree_bits[node]);
        end
    end

    // point every node on the hit path at the other subtree
    always_comb begin
        int node;
        node = 0;
        tree_next = tree_bits;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            tree_next[node] = ~hit_way[WAY_BITS-1-lvl];
            node = 2 * node + 1 + int'(hit_way[WAY_BITS-1-lvl]);
        end
    end

endmodule

//--- tag_lookup.sv
`timescale 1ns/1ps

module tag_lookup #(
    parameter int  SETS        = 16,
    parameter int  WAYS        = 4,
    parameter int  LINE_WORDS  = 8,
    localparam int INDEX_BITS  = $clog2(SETS),
    localparam int OFFSET_BITS = $clog2(LINE_WORDS),
    localparam int WAY_BITS    = $clog2(WAYS),
    localparam int TAG_BITS    = dcache_pkg::ADDR_BITS - INDEX_BITS - OFFSET_BITS
                                 - dcache_pkg::ALIGN_BITS
) (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           req_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0]   req_addr,
    input  logic [dcache_pkg::STROBE_BITS-1:0] req_strobe,
    input  logic [dcache_pkg::WORD_BITS-1:0]   req_wdata,
    output logic                           addr_ok,
    lookup_if.source                       stage,
    output logic                           miss,
    output logic [WAY_BITS-1:0]            victim_way,
    output logic                           victim_dirty,
    output logic [TAG_BITS-1:0]            victim_tag,
    output logic [INDEX_BITS-1:0]          req_index,
    output logic [TAG_BITS-1:0]            req_tag,
    input  logic                           busy,
    input  logic                           install
);
    import dcache_pkg::*;

    logic [TAG_BITS-1:0]       tag_q [SETS][WAYS];
    logic [SETS-1:0][WAYS-1:0] valid_q;
    logic [SETS-1:0][WAYS-1:0] dirty_q;
    logic [SETS-1:0][WAYS-2:0] plru_q;

    logic [OFFSET_BITS-1:0] req_offset;
    logic [WAYS-1:0]        hit_bits;
    logic                   hit;
    logic [WAY_BITS-1:0]    hit_way;
    logic [WAYS-2:0]        plru_next;

    assign req_offset = req_addr[ALIGN_BITS +: OFFSET_BITS];
    assign req_index  = req_addr[ALIGN_BITS + OFFSET_BITS +: INDEX_BITS];
    assign req_tag    = req_addr[ADDR_BITS-1 -: TAG_BITS];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_bits[w] = valid_q[req_index][w] && (tag_q[req_index][w] == req_tag);
            if (hit_bits[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit = |hit_bits;

    // no lookup while the engine owns the set
    assign addr_ok = req_valid && hit && !busy;
    assign miss    = req_valid && !hit && !busy;

    plru_tree #(
        .WAYS (WAYS)
    ) u_plru_tree (
        .tree_bits  (plru_q[req_index]),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .tree_next  (plru_next)
    );

    assign victim_dirty = valid_q[req_index][victim_way] && dirty_q[req_index][victim_way];
    assign victim_tag   = tag_q[req_index][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            plru_q  <= '0;
        end else if (install) begin
            valid_q[req_index][victim_way] <= 1'b1;
            dirty_q[req_index][victim_way] <= 1'b0;
        end else if (addr_ok) begin
            plru_q[req_index] <= plru_next;
            if (|req_strobe) begin
                dirty_q[req_index][hit_way] <= 1'b1;
            end
        end
    end

    // held request still names the victim when the refill ends
    always_ff @(posedge clk) begin
        if (install) begin
            tag_q[req_index][victim_way] <= req_tag;
        end
    end

    assign stage.fire   = addr_ok;
    assign stage.way    = hit_way;
    assign stage.index  = req_index;
    assign stage.offset = req_offset;
    assign stage.strobe = req_strobe;
    assign stage.wdata  = req_wdata;

endmodule

//--- data_stage.sv
`timescale 1ns/1ps

module data_stage #(
    parameter int  SETS       = 16,
    parameter int  WAYS       = 4,
    parameter int  LINE_WORDS = 8,
    localparam int DEPTH      = SETS * WAYS * LINE_WORDS,
    localparam int DEPTH_BITS = $clog2(DEPTH)
) (
    input  logic                             clk,
    input  logic                             resetn,
    lookup_if.sink                           stage,
    fill_if.array                            fill,
    output logic                             data_ok,
    output logic [dcache_pkg::WORD_BITS-1:0] rdata
);
    import dcache_pkg::*;

    logic [WORD_BITS-1:0]  data_q [DEPTH];
    logic [DEPTH_BITS-1:0] req_ptr;
    logic [DEPTH_BITS-1:0] fill_ptr;
    logic [WORD_BITS-1:0]  req_mask;

    // word address is way, then set, then word in line
    assign req_ptr  = {stage.way, stage.index, stage.offset};
    assign fill_ptr = {fill.way, fill.index, fill.offset};
    assign req_mask = byte_mask(stage.strobe);

    // request and fill traffic never overlap in time
    always_ff @(posedge clk) begin
        if (stage.fire) begin
            rdata           <= data_q[req_ptr];
            data_q[req_ptr] <= (data_q[req_ptr] & ~req_mask) | (stage.wdata & req_mask);
        end
        if (fill.en) begin
            fill.rdata <= data_q[fill_ptr];
            if (fill.we) begin
                data_q[fill_ptr] <= fill.wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= stage.fire;
        end
    end

endmodule

//--- miss_engine.sv
`timescale 1ns/1ps

module miss_engine #(
    parameter int  SETS        = 16,
    parameter int  WAYS        = 4,
    parameter int  LINE_WORDS  = 8,
    localparam int INDEX_BITS  = $clog2(SETS),
    localparam int OFFSET_BITS = $clog2(LINE_WORDS),
    localparam int WAY_BITS    = $clog2(WAYS),
    localparam int TAG_BITS    = dcache_pkg::ADDR_BITS - INDEX_BITS - OFFSET_BITS
                                 - dcache_pkg::ALIGN_BITS
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             miss,
    input  logic [WAY_BITS-1:0]              victim_way,
    input  logic                             victim_dirty,
    input  logic [TAG_BITS-1:0]              victim_tag,
    input  logic [INDEX_BITS-1:0]            req_index,
    input  logic [TAG_BITS-1:0]              req_tag,
    output logic                             busy,
    output logic                             install,
    fill_if.engine                           fill,
    output logic                             mem_valid,
    output logic                             mem_is_write,
    output logic [dcache_pkg::ADDR_BITS-1:0] mem_addr,
    output logic [dcache_pkg::WORD_BITS-1:0] mem_wdata,
    input  logic                             mem_ready,
    input  logic                             mem_last,
    input  logic [dcache_pkg::WORD_BITS-1:0] mem_rdata
);
    import dcache_pkg::*;

    localparam logic [1:0] S_IDLE      = 2'd0;
    localparam logic [1:0] S_COPY      = 2'd1;
    localparam logic [1:0] S_WRITEBACK = 2'd2;
    localparam logic [1:0] S_FETCH     = 2'd3;
    localparam int CNT_BITS = OFFSET_BITS + 1;
    localparam logic [CNT_BITS-1:0] COPY_DONE = CNT_BITS'(LINE_WORDS);

    logic [1:0]             state_q;
    logic [CNT_BITS-1:0]    cnt_q;
    logic [OFFSET_BITS-1:0] beat;
    logic [OFFSET_BITS-1:0] copy_slot;
    logic [WAY_BITS-1:0]    way_q;
    logic [INDEX_BITS-1:0]  index_q;
    logic [ADDR_BITS-1:0]   wb_addr_q;
    logic [ADDR_BITS-1:0]   fetch_addr_q;
    logic [WORD_BITS-1:0]   line_q [LINE_WORDS];

    assign beat      = cnt_q[OFFSET_BITS-1:0];
    // read data lags the read by one cycle
    assign copy_slot = beat - 1'b1;

    assign busy    = state_q != S_IDLE;
    assign install = state_q == S_FETCH && mem_ready && mem_last;

    assign mem_valid    = state_q == S_WRITEBACK || state_q == S_FETCH;
    assign mem_is_write = state_q == S_WRITEBACK;
    assign mem_addr     = mem_is_write ? wb_addr_q : fetch_addr_q;
    assign mem_wdata    = line_q[beat];

    // copy reads one word a cycle, refill writes each beat as it lands
    assign fill.en     = (state_q == S_COPY && cnt_q != COPY_DONE)
                         || (state_q == S_FETCH && mem_ready);
    assign fill.we     = state_q == S_FETCH;
    assign fill.way    = way_q;
    assign fill.index  = index_q;
    assign fill.offset = beat;
    assign fill.wdata  = mem_rdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    cnt_q <= '0;
                    if (miss) begin
                        state_q <= victim_dirty ? S_COPY : S_FETCH;
                    end
                end
                S_COPY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == COPY_DONE) begin
                        state_q <= S_WRITEBACK;
                        cnt_q   <= '0;
                    end
                end
                S_WRITEBACK: begin
                    if (mem_ready) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (mem_last) begin
                            state_q <= S_FETCH;
                            cnt_q   <= '0;
                        end
                    end
                end
                default: begin
                    if (mem_ready) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (mem_last) begin
                            state_q <= S_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && miss) begin
            way_q        <= victim_way;
            index_q      <= req_index;
            wb_addr_q    <= {victim_tag, req_index, {(OFFSET_BITS + ALIGN_BITS){1'b0}}};
            fetch_addr_q <= {req_tag, req_index, {(OFFSET_BITS + ALIGN_BITS){1'b0}}};
        end
        if (state_q == S_COPY && cnt_q != '0) begin
            line_q[copy_slot] <= fill.rdata;
        end
    end

endmodule

//--- dcache.sv
`timescale 1ns/1ps

module dcache #(
    parameter int  SETS        = 16,
    parameter int  WAYS        = 4,
    parameter int  LINE_WORDS  = 8,
    localparam int INDEX_BITS  = $clog2(SETS),
    localparam int WAY_BITS    = $clog2(WAYS),
    localparam int TAG_BITS    = dcache_pkg::ADDR_BITS - INDEX_BITS - $clog2(LINE_WORDS)
                                 - dcache_pkg::ALIGN_BITS
) (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               req_valid,
    input  logic [dcache_pkg::ADDR_BITS-1:0]   req_addr,
    input  logic [dcache_pkg::STROBE_BITS-1:0] req_strobe,
    input  logic [dcache_pkg::WORD_BITS-1:0]   req_wdata,
    output logic                               addr_ok,
    output logic                               data_ok,
    output logic [dcache_pkg::WORD_BITS-1:0]   rdata,
    output logic                               mem_valid,
    output logic                               mem_is_write,
    output logic [dcache_pkg::ADDR_BITS-1:0]   mem_addr,
    output logic [dcache_pkg::WORD_BITS-1:0]   mem_wdata,
    input  logic                               mem_ready,
    input  logic                               mem_last,
    input  logic [dcache_pkg::WORD_BITS-1:0]   mem_rdata
);

    logic                  miss;
    logic [WAY_BITS-1:0]   victim_way;
    logic                  victim_dirty;
    logic [TAG_BITS-1:0]   victim_tag;
    logic [INDEX_BITS-1:0] req_index;
    logic [TAG_BITS-1:0]   req_tag;
    logic                  busy;
    logic                  install;

    lookup_if #(.SETS(SETS), .WAYS(WAYS), .LINE_WORDS(LINE_WORDS)) u_lookup_if ();
    fill_if #(.SETS(SETS), .WAYS(WAYS), .LINE_WORDS(LINE_WORDS)) u_fill_if ();

    tag_lookup #(
        .SETS       (SETS),
        .WAYS       (WAYS),
        .LINE_WORDS (LINE_WORDS)
    ) u_tag_lookup (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_strobe   (req_strobe),
        .req_wdata    (req_wdata),
        .addr_ok      (addr_ok),
        .stage        (u_lookup_if.source),
        .miss         (miss),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .busy         (busy),
        .install      (install)
    );

    data_stage #(
        .SETS       (SETS),
        .WAYS       (WAYS),
        .LINE_WORDS (LINE_WORDS)
    ) u_data_stage (
        .clk     (clk),
        .resetn  (resetn),
        .stage   (u_lookup_if.sink),
        .fill    (u_fill_if.array),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    miss_engine #(
        .SETS       (SETS),
        .WAYS       (WAYS),
        .LINE_WORDS (LINE_WORDS)
    ) u_miss_engine (
        .clk          (clk),
        .resetn       (resetn),
        .miss         (miss),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .busy         (busy),
        .install      (install),
        .fill         (u_fill_if.engine),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata)
    );

endmodule

//--- dcache_properties.sv
`timescale 1ns/1ps

module dcache_properties (
    input logic                             clk,
    input logic                             resetn,
    input logic                             addr_ok,
    input logic                             data_ok,
    input logic                             mem_valid,
    input logic                             mem_ready,
    input logic                             mem_is_write,
    input logic [dcache_pkg::ADDR_BITS-1:0] mem_addr
);

    int fail_count = 0;

    // response one cycle behind the accept
    a_data_ok_follows: assert property (
        @(posedge clk) disable iff (resetn) data_ok == $past(addr_ok)
    ) else begin
        $error("data_ok does not match addr_ok of the previous cycle");
        fail_count++;
    end

    a_no_accept_in_burst: assert property (
        @(posedge clk) disable iff (resetn) !(addr_ok && mem_valid)
    ) else begin
        $error("addr_ok high during a memory burst");
        fail_count++;
    end

    // stalled beat holds the burst
    a_stall_stable: assert property (
        @(posedge clk) disable iff (resetn)
        mem_valid && !mem_ready |=> $stable(mem_addr) && $stable(mem_is_write)
    ) else begin
        $error("mem_addr or mem_is_write changed during a stall");
        fail_count++;
    end

endmodule

bind dcache dcache_properties u_dcache_properties (
    .clk          (clk),
    .resetn       (resetn),
    .addr_ok      (addr_ok),
    .data_ok      (data_ok),
    .mem_valid    (mem_valid),
    .mem_ready    (mem_ready),
    .mem_is_write (mem_is_write),
    .mem_addr     (mem_addr)
);

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int SETS         = 16;
    localparam int WAYS         = 4;
    localparam int LINE_WORDS   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 1;
    localparam int WAIT_LIMIT   = 400;
    localparam int MEM_WORDS    = 4096;
    localparam logic [WORD_BITS-1:0] MEM_KEY    = 32'h6b2e_91d4;
    localparam logic [ADDR_BITS-1:0] EVICT_ADDR = 32'h0000_0008;
    localparam logic [WORD_BITS-1:0] EVICT_DATA = 32'h1357_9bdf;

    logic                   clk = 1'b0;
    logic                   resetn;
    logic                   req_valid;
    logic [ADDR_BITS-1:0]   req_addr;
    logic [STROBE_BITS-1:0] req_strobe;
    logic [WORD_BITS-1:0]   req_wdata;
    logic                   addr_ok;
    logic                   data_ok;
    logic [WORD_BITS-1:0]   rdata;
    logic                   mem_valid;
    logic                   mem_is_write;
    logic [ADDR_BITS-1:0]   mem_addr;
    logic [WORD_BITS-1:0]   mem_wdata;
    logic                   mem_ready;
    logic                   mem_last;
    logic [WORD_BITS-1:0]   mem_rdata;

    logic [WORD_BITS-1:0]   mem_words [MEM_WORDS];
    int                     beat_count = 0;
    logic [ADDR_BITS-1:0]   first_read_base = '0;
    bit                     read_seen = 1'b0;
    logic [31:0]            lfsr_state = 32'hd385a53c;
    int                     cycle_count = 0;
    int                     value_errors = 0;
    int                     other_errors = 0;
    int                     assert_errors = 0;

    logic [ADDR_BITS-1:0]   tab_addr [$];
    logic [STROBE_BITS-1:0] tab_strobe [$];
    logic [WORD_BITS-1:0]   tab_wdata [$];
    logic [WORD_BITS-1:0]   tab_expect [$];

    dcache #(
        .SETS       (SETS),
        .WAYS       (WAYS),
        .LINE_WORDS (LINE_WORDS)
    ) u_dcache (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_strobe   (req_strobe),
        .req_wdata    (req_wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [WORD_BITS-1:0] initial_word(input logic [ADDR_BITS-1:0] addr);
        return {2'b00, addr[ADDR_BITS-1:2]} ^ MEM_KEY;
    endfunction

    // strobed bytes come from the new word
    function automatic logic [WORD_BITS-1:0] lane_merge(
        input logic [WORD_BITS-1:0]   old_word,
        input logic [WORD_BITS-1:0]   new_word,
        input logic [STROBE_BITS-1:0] strobe
    );
        logic [WORD_BITS-1:0] merged;
        int                   b;
        merged = old_word;
        for (b = 0; b < STROBE_BITS; b++) begin
            if (strobe[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            value_errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic add_entry(input logic [ADDR_BITS-1:0] addr,
                             input logic [STROBE_BITS-1:0] strobe,
                             input logic [WORD_BITS-1:0] wdata,
                             input logic [WORD_BITS-1:0] expect_word);
        tab_addr.push_back(addr);
        tab_strobe.push_back(strobe);
        tab_wdata.push_back(wdata);
        tab_expect.push_back(expect_word);
    endtask

    task automatic build_table();
        logic [WORD_BITS-1:0] w104;
        w104 = lane_merge(initial_word(32'h104), 32'ha1b2_c3d4, 4'b0110);
        // read miss, partial write hit, read back
        add_entry(32'h0000_0104, 4'b0000, 32'h0, initial_word(32'h104));
        add_entry(32'h0000_0104, 4'b0110, 32'ha1b2_c3d4, initial_word(32'h104));
        add_entry(32'h0000_0104, 4'b0000, 32'h0, w104);
        add_entry(32'h0000_0108, 4'b0000, 32'h0, initial_word(32'h108));
        // set 0 filled by four tags, the fifth evicts the dirty line
        add_entry(EVICT_ADDR, 4'b1111, EVICT_DATA, initial_word(EVICT_ADDR));
        add_entry(32'h0000_0200, 4'b0000, 32'h0, initial_word(32'h200));
        add_entry(32'h0000_040c, 4'b0000, 32'h0, initial_word(32'h40c));
        add_entry(32'h0000_0610, 4'b0000, 32'h0, initial_word(32'h610));
        add_entry(32'h0000_0814, 4'b0000, 32'h0, initial_word(32'h814));
        add_entry(EVICT_ADDR, 4'b0000, 32'h0, EVICT_DATA);
        add_entry(32'h0000_000c, 4'b1000, 32'h5e00_0000, initial_word(32'h00c));
        add_entry(32'h0000_000c, 4'b0000, 32'h0,
                  lane_merge(initial_word(32'h00c), 32'h5e00_0000, 4'b1000));
        add_entry(32'h0000_0104, 4'b0001, 32'h0000_00ee, w104);
        add_entry(32'h0000_0104, 4'b0000, 32'h0, lane_merge(w104, 32'h0000_00ee, 4'b0001));
    endtask

    task automatic wait_handshake(input string name, input bit pick_data,
                                  output int at_cycle, output bit seen);
        int n;
        seen = 1'b0;
        at_cycle = 0;
        for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge clk);
            if ((pick_data ? data_ok : addr_ok) === 1'b1) begin
                seen = 1'b1;
                at_cycle = cycle_count;
            end
        end
        if (!seen) begin
            other_errors++;
            $display("timeout at %0t ns while waiting for %s", $time, name);
        end
    endtask

    // memory beat for this cycle, ready drawn at random
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (mem_valid === 1'b1) begin
            lfsr_state = lfsr_step(lfsr_state);
            mem_ready = lfsr_state[0];
        end else begin
            mem_ready = 1'b0;
        end
        mem_last = mem_ready && (beat_count == LINE_WORDS - 1);
        if (mem_ready) begin
            mem_rdata = mem_words[int'(mem_addr[13:2]) + beat_count];
        end
    end

    always @(negedge clk) begin
        if (resetn === 1'b0 && mem_valid === 1'b1 && mem_ready) begin
            if (mem_addr[ADDR_BITS-1:14] != '0 || mem_addr[4:0] != '0) begin
                other_errors++;
                $display("burst address %h is outside the memory model or unaligned", mem_addr);
            end
            if (mem_is_write) begin
                mem_words[int'(mem_addr[13:2]) + beat_count] = mem_wdata;
            end else if (!read_seen) begin
                first_read_base = mem_addr;
                read_seen = 1'b1;
            end
            beat_count = (beat_count == LINE_WORDS - 1) ? 0 : beat_count + 1;
        end
    end

    initial begin
        int  i;
        int  accept_cycle;
        int  data_cycle;
        bit  seen;
        bit  hung;
        resetn     = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_strobe = '0;
        req_wdata  = '0;
        mem_ready  = 1'b0;
        mem_last   = 1'b0;
        mem_rdata  = '0;
        hung       = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = initial_word(ADDR_BITS'(i * 4));
        end
        build_table();

        for (i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("addr_ok", addr_ok, 32'd0);
            check_value("data_ok", data_ok, 32'd0);
            check_value("mem_valid", mem_valid, 32'd0);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b0;
        @(negedge clk);
        check_value("addr_ok", addr_ok, 32'd0);
        check_value("data_ok", data_ok, 32'd0);
        check_value("mem_valid", mem_valid, 32'd0);

        for (i = 0; i < tab_addr.size() && !hung; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            req_valid  = 1'b1;
            req_addr   = tab_addr[i];
            req_strobe = tab_strobe[i];
            req_wdata  = tab_wdata[i];
            wait_handshake("addr_ok", 1'b0, accept_cycle, seen);
            if (!seen) begin
                hung = 1'b1;
            end else begin
                @(posedge clk);
                #DRIVE_DELAY;
                req_valid = 1'b0;
                wait_handshake("data_ok", 1'b1, data_cycle, seen);
                if (!seen) begin
                    hung = 1'b1;
                end else begin
                    check_value("data_ok delay", data_cycle - accept_cycle, 32'd1);
                    check_value("rdata", rdata, tab_expect[i]);
                end
            end
        end

        if (!hung) begin
            check_value("first read burst base", first_read_base, 32'h0000_0100);
            check_value("memory word after writeback", mem_words[EVICT_ADDR[13:2]], EVICT_DATA);
        end

        assert_errors = u_dcache.u_dcache_properties.fail_count;
        $display("value errors %0d, other errors %0d, assertion errors %0d",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- dcache.f
dcache_pkg.sv
dcache_if.sv
plru_tree.sv
tag_lookup.sv
data_stage.sv
miss_engine.sv
dcache.sv
dcache_properties.sv
tb_dcache.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_dcache
FILELIST  = dcache.f
MDIR      = obj_dir
LOG       = simulate.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	! grep -q "Regression failed" $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
